/* hw/tcdm_consts.svh */
// TCDM size constants: lanes, banks, bank depth, data width and derived widths
`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// wide port and bank array shape
`define TCDM_NB_LANES   4
`define TCDM_NB_BANKS   4   // never fewer than lanes
`define TCDM_BANK_WORDS 64

// word and byte-enable widths
`define TCDM_DATA_W     32
`define TCDM_BE_W       (`TCDM_DATA_W / 8)

// address fields, word addressed
`define TCDM_ORDER_W    2   // log2 of bank count
`define TCDM_ROW_W      6   // log2 of bank words
`define TCDM_WADDR_W    (`TCDM_ORDER_W + `TCDM_ROW_W)

`endif

/* hw/tcdm_bank_pkg.sv */
// bank-side types: word, byte enable, bank row, bank request and response structs
`include "tcdm_consts.svh"

package tcdm_bank_pkg;

  typedef logic [`TCDM_DATA_W-1:0] word_t;
  typedef logic [`TCDM_BE_W-1:0]   be_t;
  typedef logic [`TCDM_ROW_W-1:0]  bank_row_t;   // row inside a single bank

  // one bank request, wen high means read
  typedef struct packed {
    logic      req;
    logic      wen;
    bank_row_t row;
    be_t       be;
    word_t     data;
  } bank_req_t;

  // bank response, r_data valid one cycle after a read
  typedef struct packed {
    logic  gnt;
    word_t r_data;
  } bank_rsp_t;

endpackage

/* hw/wide_port_pkg.sv */
// accelerator-side types: word address, order, lane vectors, wide and lane structs
`include "tcdm_consts.svh"

package wide_port_pkg;
  import tcdm_bank_pkg::*;

  typedef logic [`TCDM_WADDR_W-1:0] word_addr_t;   // global word address
  typedef logic [`TCDM_ORDER_W-1:0] bank_order_t;  // base mod bank count

  typedef word_t [`TCDM_NB_LANES-1:0] lane_words_t;
  typedef be_t   [`TCDM_NB_LANES-1:0] lane_be_t;

  typedef struct packed {
    logic        wen;    // high means read
    word_addr_t  base;
    lane_words_t data;
    lane_be_t    be;
  } wide_req_t;

  typedef struct packed {
    logic        wen;    // echo of the request
    lane_words_t r_data;
  } wide_rsp_t;

  typedef struct packed {
    word_addr_t addr;
    be_t        be;
    word_t      data;
  } lane_req_t;

endpackage

/* hw/tcdm_bank.sv */
// tcdm bank: single-port word memory with byte-enable writes and registered read data
`timescale 1ns/1ps
`include "tcdm_consts.svh"

module tcdm_bank
  import tcdm_bank_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  bank_req_t bank_req_i,
  output bank_rsp_t bank_rsp_o
);

  word_t mem [`TCDM_BANK_WORDS];
  word_t r_data_q;

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && !bank_req_i.wen) begin
      for (int i = 0; i < `TCDM_BE_W; i++) begin
        if (bank_req_i.be[i]) begin
          mem[bank_req_i.row][8*i +: 8] <= bank_req_i.data[8*i +: 8];
        end
      end
    end
  end

  // read data held until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_data_q <= '0;
    end else if (bank_req_i.req && bank_req_i.wen) begin
      r_data_q <= mem[bank_req_i.row];
    end
  end

  assign bank_rsp_o.gnt    = 1'b1;  // no conflicts, always granted
  assign bank_rsp_o.r_data = r_data_q;

endmodule

/* hw/lane_router.sv */
// lane router: lane-to-bank rotation, request merge, grant, r_valid and read data return
`timescale 1ns/1ps
`include "tcdm_consts.svh"

module lane_router
  import tcdm_bank_pkg::*;
  import wide_port_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  bank_order_t                    order_i,
  input  logic                           lane_valid_i,
  input  logic                           lane_wen_i,
  input  lane_req_t [`TCDM_NB_LANES-1:0] lane_req_i,
  output logic                           lane_gnt_o,
  output logic                           lane_r_valid_o,
  output lane_words_t                    lane_r_data_o,
  output bank_req_t [`TCDM_NB_BANKS-1:0] bank_req_o,
  input  bank_rsp_t [`TCDM_NB_BANKS-1:0] bank_rsp_i
);

  logic [`TCDM_NB_LANES-1:0][`TCDM_NB_BANKS-1:0] ma_req;  // lane to bank one-hot
  logic [`TCDM_NB_BANKS-1:0] bank_req, bank_gnt;
  logic        r_valid_q;
  bank_order_t order_q;

  for (genvar k = 0; k < `TCDM_NB_LANES; k++) begin : gen_lane
    bank_order_t sel, rd_sel;
    assign sel    = order_i + bank_order_t'(k);
    assign rd_sel = order_q + bank_order_t'(k);   // same rotation, one cycle late
    for (genvar b = 0; b < `TCDM_NB_BANKS; b++) begin : gen_sel
      assign ma_req[k][b] = lane_valid_i & (sel == bank_order_t'(b));
    end
    assign lane_r_data_o[k] = bank_rsp_i[rd_sel].r_data;
  end

  // OR together whatever lane landed on each bank
  for (genvar b = 0; b < `TCDM_NB_BANKS; b++) begin : gen_bank
    always_comb begin
      bank_req_o[b]     = '0;
      bank_req_o[b].wen = lane_wen_i;
      for (int j = 0; j < `TCDM_NB_LANES; j++) begin
        bank_req_o[b].req  |= ma_req[j][b];
        bank_req_o[b].row  |= ma_req[j][b] ?
                              lane_req_i[j].addr[`TCDM_WADDR_W-1:`TCDM_ORDER_W] : '0;
        bank_req_o[b].be   |= ma_req[j][b] ? lane_req_i[j].be : '0;
        bank_req_o[b].data |= ma_req[j][b] ? lane_req_i[j].data : '0;
      end
    end
    assign bank_req[b] = bank_req_o[b].req;
    assign bank_gnt[b] = bank_rsp_i[b].gnt;
  end

  // all-or-nothing grant
  assign lane_gnt_o = &(~bank_req | bank_gnt);

  // fixed latency of one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (clear_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= lane_valid_i & lane_gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_valid_i & lane_gnt_o) order_q <= order_i;
  end

  assign lane_r_valid_o = r_valid_q;

endmodule

/* hw/wide_port_splitter.sv */
// wide port splitter: request accept, per-lane addresses and order, response hold FSM
`timescale 1ns/1ps
`include "tcdm_consts.svh"

module wide_port_splitter
  import wide_port_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  wide_req_t                      req_i,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output wide_rsp_t                      rsp_o,
  output logic                           lane_valid_o,
  output logic                           lane_wen_o,
  output lane_req_t [`TCDM_NB_LANES-1:0] lane_req_o,
  output bank_order_t                    order_o,
  input  logic                           lane_gnt_i,
  input  logic                           lane_r_valid_i,
  input  lane_words_t                    lane_r_data_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,   // access issued, data due next cycle
    ST_HOLD    // response register full
  } state_e;

  state_e    state_q, state_d;
  wide_rsp_t rsp_q;
  logic      accept;

  // only one access in flight, so ready means idle
  assign lane_valid_o = req_valid_i & (state_q == ST_IDLE);
  assign req_ready_o  = (state_q == ST_IDLE) & lane_gnt_i;
  assign accept       = lane_valid_o & lane_gnt_i;

  assign lane_wen_o = req_i.wen;
  assign order_o    = req_i.base[`TCDM_ORDER_W-1:0];

  // lane k targets word base + k
  for (genvar k = 0; k < `TCDM_NB_LANES; k++) begin : gen_lane
    assign lane_req_o[k].addr = req_i.base + word_addr_t'(k);
    assign lane_req_o[k].be   = req_i.be[k];
    assign lane_req_o[k].data = req_i.data[k];
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (accept) state_d = ST_WAIT;
      end
      ST_WAIT: begin
        if (lane_r_valid_i) state_d = ST_HOLD;
      end
      ST_HOLD: begin
        if (rsp_ready_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
    if (clear_i) state_d = ST_IDLE;  // drops a pending response
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (accept) rsp_q.wen <= req_i.wen;
    if (state_q == ST_WAIT && lane_r_valid_i) begin
      rsp_q.r_data <= rsp_q.wen ? lane_r_data_i : '0;
    end
  end

  assign rsp_valid_o = (state_q == ST_HOLD);
  assign rsp_o       = rsp_q;

endmodule

/* hw/tcdm_subsystem.sv */
// tcdm subsystem top: wide port splitter, lane router and bank array
`timescale 1ns/1ps
`include "tcdm_consts.svh"

module tcdm_subsystem
  import tcdm_bank_pkg::*;
  import wide_port_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  wide_req_t req_i,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output wide_rsp_t rsp_o
);

  lane_req_t [`TCDM_NB_LANES-1:0] lane_req;
  logic        lane_valid, lane_wen;
  logic        lane_gnt, lane_r_valid;
  lane_words_t lane_r_data;
  bank_order_t order;

  bank_req_t [`TCDM_NB_BANKS-1:0] bank_req;
  bank_rsp_t [`TCDM_NB_BANKS-1:0] bank_rsp;

  wide_port_splitter i_splitter (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear_i      ),
    .req_valid_i    ( req_valid_i  ),
    .req_ready_o    ( req_ready_o  ),
    .req_i          ( req_i        ),
    .rsp_valid_o    ( rsp_valid_o  ),
    .rsp_ready_i    ( rsp_ready_i  ),
    .rsp_o          ( rsp_o        ),
    .lane_valid_o   ( lane_valid   ),
    .lane_wen_o     ( lane_wen     ),
    .lane_req_o     ( lane_req     ),
    .order_o        ( order        ),
    .lane_gnt_i     ( lane_gnt     ),
    .lane_r_valid_i ( lane_r_valid ),
    .lane_r_data_i  ( lane_r_data  )
  );

  lane_router i_router (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear_i      ),
    .order_i        ( order        ),
    .lane_valid_i   ( lane_valid   ),
    .lane_wen_i     ( lane_wen     ),
    .lane_req_i     ( lane_req     ),
    .lane_gnt_o     ( lane_gnt     ),
    .lane_r_valid_o ( lane_r_valid ),
    .lane_r_data_o  ( lane_r_data  ),
    .bank_req_o     ( bank_req     ),
    .bank_rsp_i     ( bank_rsp     )
  );

  // word-interleaved banks
  for (genvar b = 0; b < `TCDM_NB_BANKS; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i      ( clk_i       ),
      .rst_ni     ( rst_ni      ),
      .bank_req_i ( bank_req[b] ),
      .bank_rsp_o ( bank_rsp[b] )
    );
  end

endmodule

/* sim/tcdm_properties.sv */
// tcdm handshake and reset assertions, bound into the subsystem top
`timescale 1ns/1ps

module tcdm_properties
  import wide_port_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      clear_i,
  input logic      req_valid_i,
  input logic      req_ready_o,
  input logic      rsp_valid_o,
  input logic      rsp_ready_i,
  input wide_rsp_t rsp_o
);

  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    rsp_valid_o && !rsp_ready_i |=> $stable(rsp_o))
    else $error("rsp_o changed while the response was stalled");

  no_ready_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> !req_ready_o)
    else $error("req_ready_o high while a response is held");

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !rsp_valid_o)
    else $error("rsp_valid_o high during reset");

  two_cycle_latency: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    req_valid_i && req_ready_o |=> !rsp_valid_o ##1 rsp_valid_o)
    else $error("response did not arrive two cycles after the request");

endmodule

bind tcdm_subsystem tcdm_properties i_properties (.*);

/* sim/tcdm_checker.sv */
// tcdm checker: shadow memory, response compare, latency check and per-test lines
`timescale 1ns/1ps
`include "tcdm_consts.svh"

module tcdm_checker
  import tcdm_bank_pkg::*;
  import wide_port_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         req_valid_i,
  input  logic         req_ready_i,
  input  wide_req_t    req_i,
  input  logic         rsp_valid_i,
  input  logic         rsp_ready_i,
  input  wide_rsp_t    rsp_i,
  input  logic [127:0] test_name_i,
  output int           test_count_o,
  output int           error_count_o
);

  word_t        shadow [2**`TCDM_WADDR_W];  // starts as x, read only where written
  wide_rsp_t    exp_q [$];
  logic [127:0] name_q [$];
  int           tests = 0;
  int           errors = 0;
  int           cycle = 0;
  int           accept_cycle = 0;
  logic         rsp_valid_prev = 1'b0;

  assign test_count_o  = tests;
  assign error_count_o = errors;

  always @(posedge clk_i) begin : check
    wide_rsp_t    exp;
    wide_rsp_t    got;
    word_addr_t   a;
    logic [127:0] nm;
    cycle++;
    if (rst_ni) begin
      if (clear_i && exp_q.size() > 0) begin
        $display("%0s: response dropped by clear", name_q[0]);
        tests++;
        exp_q.delete();
        name_q.delete();
      end
      if (rsp_valid_i && !rsp_valid_prev && (cycle - accept_cycle) != 2) begin
        $display("response came %0d cycles after accept instead of 2",
                 cycle - accept_cycle);
        errors++;
      end
      if (rsp_valid_i && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("response handshake with no request outstanding");
          errors++;
        end else begin
          exp = exp_q.pop_front();
          nm  = name_q.pop_front();
          got = rsp_i;
          tests++;
          if (got !== exp) begin
            $display("MISMATCH %0s expected %h actual %h", nm, exp, got);
            errors++;
          end else begin
            $display("%0s: ok", nm);
          end
        end
      end
      // lane k works on word base + k
      if (req_valid_i && req_ready_i) begin
        accept_cycle = cycle;
        exp.wen      = req_i.wen;
        for (int k = 0; k < `TCDM_NB_LANES; k++) begin
          a = req_i.base + word_addr_t'(k);
          if (req_i.wen) begin
            exp.r_data[k] = shadow[a];
          end else begin
            for (int i = 0; i < `TCDM_BE_W; i++) begin
              if (req_i.be[k][i]) shadow[a][8*i +: 8] = req_i.data[k][8*i +: 8];
            end
            exp.r_data[k] = '0;  // writes answer with zeros
          end
        end
        exp_q.push_back(exp);
        name_q.push_back(test_name_i);
      end
    end
    rsp_valid_prev = rsp_valid_i;
  end

endmodule

/* sim/tb_tcdm_subsystem.sv */
// tcdm subsystem testbench top: clock, reset, lfsr, pattern reader and stimulus driver
`timescale 1ns/1ps

module tb_tcdm_subsystem
  import wide_port_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 50;

  logic         clk_i;
  logic         rst_ni;
  logic         clear_i;
  logic         req_valid_i;
  logic         req_ready_o;
  wide_req_t    req_i;
  logic         rsp_valid_o;
  logic         rsp_ready_i;
  wide_rsp_t    rsp_o;
  logic [127:0] test_name;   // ascii name read by the checker
  logic [15:0]  lfsr;
  int           test_count;
  int           error_count;

  tcdm_subsystem tcdm_subsystem_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_i       ( req_i       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_o       ( rsp_o       )
  );

  tcdm_checker i_checker (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .req_valid_i   ( req_valid_i ),
    .req_ready_i   ( req_ready_o ),
    .req_i         ( req_i       ),
    .rsp_valid_i   ( rsp_valid_o ),
    .rsp_ready_i   ( rsp_ready_i ),
    .rsp_i         ( rsp_o       ),
    .test_name_i   ( test_name   ),
    .test_count_o  ( test_count  ),
    .error_count_o ( error_count )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic wait_req_ready(output bit ok);
    int n;
    ok = 1'b1;
    n  = 0;
    while (!req_ready_o) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > TIMEOUT_CYCLES) begin
        $display("timeout: req_ready_o stayed low for %0d cycles", n);
        ok = 1'b0;
        break;
      end
    end
  endtask

  task automatic wait_rsp_valid(output bit ok);
    int n;
    ok = 1'b1;
    n  = 0;
    while (!rsp_valid_o) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > TIMEOUT_CYCLES) begin
        $display("timeout: no response within %0d cycles", n);
        ok = 1'b0;
        break;
      end
    end
  endtask

  // request stays valid until a rising edge sees ready
  task automatic send_request(input logic [127:0] nm, input logic [7:0] op,
                              input word_addr_t base, input lane_words_t data,
                              input lane_be_t be, output bit ok);
    test_name   = nm;
    req_i.wen   = (op != "W");
    req_i.base  = base;
    req_i.data  = data;
    req_i.be    = be;
    req_valid_i = 1'b1;
    #1;
    wait_req_ready(ok);
    if (ok) begin
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
  endtask

  // stall the held response, then accept it or drop it with clear_i
  task automatic finish_response(input logic [7:0] op, input int stall, output bit ok);
    int extra;
    extra = 0;
    for (int i = 0; i < 2; i++) begin
      extra = (extra << 1) | int'(lfsr[0]);  // one step per bit taken
      lfsr  = lfsr_next(lfsr);
    end
    wait_rsp_valid(ok);
    if (!ok) return;
    repeat (stall + extra) begin
      @(posedge clk_i);
      #1;
    end
    if (op == "C") begin
      clear_i = 1'b1;
      @(posedge clk_i);
      #1;
      clear_i = 1'b0;
    end else begin
      rsp_ready_i = 1'b1;
      @(posedge clk_i);
      #1;
      rsp_ready_i = 1'b0;
    end
  endtask

  initial begin
    int           fd;
    int           n;
    int           cnt;
    int           stall;
    int           prev_stall;
    string        line;
    logic [127:0] name_v;
    logic [7:0]   op_v;
    logic [7:0]   prev_op;
    logic [31:0]  base_v;
    logic [31:0]  d0, d1, d2, d3;
    logic [31:0]  be0, be1, be2, be3;
    bit           req_ok;
    bit           rsp_ok;
    bit           have_prev;
    bit           run_failed;

    clear_i     = 1'b0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b0;
    req_i       = '0;
    test_name   = '0;
    lfsr        = 16'd50021;
    run_failed  = 1'b0;
    have_prev   = 1'b0;
    prev_op     = '0;
    prev_stall  = 0;
    rst_ni      = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    fd = $fopen("sim/tcdm_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file");
      run_failed = 1'b1;
    end else begin
      while (!run_failed && !$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue;  // blank or comment
        cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %d", name_v, op_v, base_v,
                      d0, d1, d2, d3, be0, be1, be2, be3, stall);
        if (cnt != 12) begin
          $display("pattern line could not be parsed: %s", line);
          run_failed = 1'b1;
          continue;
        end
        // next request waits while the previous response is stalled
        rsp_ok = 1'b1;
        fork
          send_request(name_v, op_v, base_v[7:0], {d3, d2, d1, d0},
                       {be3[3:0], be2[3:0], be1[3:0], be0[3:0]}, req_ok);
          if (have_prev) finish_response(prev_op, prev_stall, rsp_ok);
        join
        if (!req_ok || !rsp_ok) run_failed = 1'b1;
        prev_op    = op_v;
        prev_stall = stall;
        have_prev  = 1'b1;
      end
      $fclose(fd);
      if (have_prev && !run_failed) begin
        finish_response(prev_op, prev_stall, rsp_ok);
        if (!rsp_ok) run_failed = 1'b1;
      end
    end

    repeat (4) @(posedge clk_i);
    $display("tests: %0d  errors: %0d", test_count, error_count + int'(run_failed));
    if (run_failed || error_count != 0) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  end

endmodule

/* sim/tcdm_patterns.txt */
# name op base d0 d1 d2 d3 be0 be1 be2 be3 stall (hex fields, stall in decimal)
# op W writes, R reads, C reads and drops the held response with clear_i
w_aligned W 00 11111111 22222222 33333333 44444444 f f f f 0
r_aligned R 00 0 0 0 0 0 0 0 0 0
w_order1 W 05 a0a0a0a0 b1b1b1b1 c2c2c2c2 d3d3d3d3 f f f f 0
r_order1 R 05 0 0 0 0 0 0 0 0 0
w_order2 W 0a 01020304 05060708 090a0b0c 0d0e0f10 f f f f 1
r_order2 R 0a 0 0 0 0 0 0 0 0 0
w_order3 W 0f deadbeef cafef00d 12345678 9abcdef0 f f f f 0
r_order3 R 0f 0 0 0 0 0 0 0 0 1
w_high W fc 55555555 66666666 77777777 88888888 f f f f 0
r_high R fc 0 0 0 0 0 0 0 0 2
w_partial W 00 aabbccdd aabbccdd aabbccdd aabbccdd 1 3 8 c 0
r_partial R 00 0 0 0 0 0 0 0 0 1
w_stall W 20 13579bdf 2468ace0 0f0f0f0f f0f0f0f0 f f f f 5
r_stall R 20 0 0 0 0 0 0 0 0 7
w_part2 W 0a ffffffff eeeeeeee dddddddd cccccccc 6 9 0 f 0
r_part2 R 0a 0 0 0 0 0 0 0 0 0
c_clear C 20 0 0 0 0 0 0 0 0 3
r_after R 20 0 0 0 0 0 0 0 0 0
w_back W 30 00000001 00000002 00000003 00000004 f f f f 1
r_back R 30 0 0 0 0 0 0 0 0 2
r_again R 05 0 0 0 0 0 0 0 0 4
w_order3b W 13 fedcba98 76543210 0badf00d 600dcafe f f f f 0
r_order3b R 13 0 0 0 0 0 0 0 0 0
c_clear2 C 13 0 0 0 0 0 0 0 0 0
r_cross R 11 0 0 0 0 0 0 0 0 3

/* project.f */
+incdir+hw
hw/tcdm_bank_pkg.sv
hw/wide_port_pkg.sv
hw/tcdm_bank.sv
hw/lane_router.sv
hw/wide_port_splitter.sv
hw/tcdm_subsystem.sv
sim/tcdm_properties.sv
sim/tcdm_checker.sv
sim/tb_tcdm_subsystem.sv

/* Makefile */
# Verilator build, run, lint and clean for the TCDM subsystem

VERILATOR ?= verilator
TOP       ?= tb_tcdm_subsystem
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation did not finish"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
